// File: design/dsp_pkg.sv
// DSP slice shared definitions
// Widths, typed vectors and the packed operation word for the 20x18 MAC slice

package dsp_pkg;

    // Datapath widths
    localparam int A_W     = 20;
    localparam int B_W     = 18;
    localparam int PROD_W  = A_W + B_W;
    localparam int ACC_W   = 64;
    localparam int Z_W     = 38;
    localparam int SHIFT_W = 6;

    typedef logic [A_W-1:0]     operand_a_t;
    typedef logic [B_W-1:0]     operand_b_t;

    // Accumulator word, also used for the extended product and the adder sum
    typedef logic [ACC_W-1:0]   acc_t;

    typedef logic [Z_W-1:0]     result_t;
    typedef logic [SHIFT_W-1:0] shift_t;

    // One operation, operands plus all per-operation controls
    typedef struct packed {
        operand_a_t a;
        operand_b_t b;
        logic       unsigned_a;
        logic       unsigned_b;
        // Negate the product before the add
        logic       subtract;
        // Write the sum into the accumulator
        logic       load_acc;
        // Zero feedback, restarts accumulation
        logic       acc_zero;
        // 1 selects processed sum, 0 selects raw product
        logic       out_sum;
        logic       round_en;
        logic       saturate_en;
        shift_t     shift;
    } dsp_op_t;

endpackage

// File: design/dsp_input_stage.sv
// DSP slice input register
// Captures the operation word and its valid flag once per cycle

`timescale 1ns/1ps

module dsp_input_stage (
    input  logic             clock_i,
    input  logic             s_reset,

    input  logic             op_valid_i,
    input  dsp_pkg::dsp_op_t op_i,

    output logic             reg_valid_o,
    output dsp_pkg::dsp_op_t reg_op_o
);

    // Operation and valid move together, no stall
    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            reg_valid_o <= 1'b0;
            reg_op_o    <= '0;
        end else begin
            reg_valid_o <= op_valid_i;
            reg_op_o    <= op_i;
        end
    end

    // Source side must present clean operands with every valid
    a_op_known: assert property (
        @(posedge clock_i) disable iff (s_reset)
        op_valid_i |-> !$isunknown(op_i)
    );

endmodule

// File: design/dsp_multiplier.sv
// DSP slice multiplier
// 20x18 multiply with per-operand signedness, extended to accumulator width

`timescale 1ns/1ps

module dsp_multiplier (
    input  dsp_pkg::dsp_op_t op_i,
    output dsp_pkg::acc_t    product_o
);

    import dsp_pkg::*;

    logic              signed_mode;
    logic              neg_a;
    logic              neg_b;
    operand_a_t        mag_a;
    operand_b_t        mag_b;
    logic [PROD_W-1:0] mag_prod;
    logic [PROD_W-1:0] prod;

    // Signed unless both operands are flagged unsigned
    assign signed_mode = !(op_i.unsigned_a && op_i.unsigned_b);

    // Operand is negative only when its own flag says signed
    assign neg_a = op_i.a[A_W-1] && !op_i.unsigned_a;
    assign neg_b = op_i.b[B_W-1] && !op_i.unsigned_b;

    assign mag_a = neg_a ? (~op_i.a + 1'b1) : op_i.a;
    assign mag_b = neg_b ? (~op_i.b + 1'b1) : op_i.b;

    // Unsigned magnitude multiply
    assign mag_prod = mag_a * mag_b;

    // Restore sign
    assign prod = (neg_a ^ neg_b) ? (~mag_prod + 1'b1) : mag_prod;

    // Zero fill in unsigned mode, sign fill otherwise
    assign product_o = signed_mode ?
        {{(ACC_W-PROD_W){prod[PROD_W-1]}}, prod} :
        {{(ACC_W-PROD_W){1'b0}}, prod};

endmodule

// File: design/dsp_accumulator.sv
// DSP slice adder and accumulator register
// Adds the optionally negated product to the feedback or to zero

`timescale 1ns/1ps

module dsp_accumulator (
    input  logic             clock_i,
    input  logic             s_reset,

    input  logic             valid_i,
    input  dsp_pkg::dsp_op_t op_i,
    input  dsp_pkg::acc_t    product_i,

    output dsp_pkg::acc_t    sum_o
);

    import dsp_pkg::*;

    acc_t acc_q;
    acc_t addend;
    acc_t term;
    logic acc_load;

    // Feedback or restart from zero
    assign addend = op_i.acc_zero ? '0 : acc_q;

    // Two's complement negate for subtract
    assign term = op_i.subtract ? (~product_i + 1'b1) : product_i;

    assign sum_o = term + addend;

    // Only valid operations may touch the accumulator
    assign acc_load = valid_i && op_i.load_acc;

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            acc_q <= '0;
        end else if (acc_load) begin
            acc_q <= sum_o;
        end
    end

    // Accumulator holds across cycles with no load
    a_acc_hold: assert property (
        @(posedge clock_i) disable iff (s_reset)
        !acc_load |=> $stable(acc_q)
    );

endmodule

// File: design/dsp_output_stage.sv
// DSP slice output stage
// Round, shift and saturate of the sum, product/sum select, output register

`timescale 1ns/1ps

module dsp_output_stage (
    input  logic             clock_i,
    input  logic             s_reset,

    input  logic             valid_i,
    input  dsp_pkg::dsp_op_t op_i,
    input  dsp_pkg::acc_t    product_i,
    input  dsp_pkg::acc_t    sum_i,

    output logic             z_valid_o,
    output dsp_pkg::result_t z_o
);

    import dsp_pkg::*;

    logic                    signed_mode;
    acc_t                    rnd_val;
    logic signed [ACC_W-1:0] rnd_signed;
    acc_t                    shr_arith;
    acc_t                    shr_val;
    logic                    ovf_u;
    logic                    ovf_s;
    result_t                 sat_val;
    result_t                 z_next;

    assign signed_mode = !(op_i.unsigned_a && op_i.unsigned_b);

    // Add half an LSB of the shifted result
    assign rnd_val = (op_i.round_en && (op_i.shift != '0)) ?
        (sum_i + (acc_t'(1) << (op_i.shift - 1'b1))) : sum_i;

    // Arithmetic shift needs a signed operand
    assign rnd_signed = rnd_val;
    assign shr_arith  = rnd_signed >>> op_i.shift;

    assign shr_val = signed_mode ? shr_arith : (rnd_val >> op_i.shift);

    // Unsigned overflow means anything set above the result width
    assign ovf_u = |shr_val[ACC_W-1:Z_W];

    // Signed overflow when the top bits are not all copies of the sign
    assign ovf_s = !((&shr_val[ACC_W-1:Z_W-1]) || !(|shr_val[ACC_W-1:Z_W-1]));

    always_comb begin
        sat_val = shr_val[Z_W-1:0];
        if (op_i.saturate_en) begin
            if (!signed_mode && ovf_u) begin
                sat_val = '1;
            end else if (signed_mode && ovf_s) begin
                // Clamp to max positive or most negative
                sat_val = {shr_val[ACC_W-1], {(Z_W-1){!shr_val[ACC_W-1]}}};
            end
        end
    end

    assign z_next = op_i.out_sum ? sat_val : product_i[Z_W-1:0];

    // Result held between valid operations
    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            z_valid_o <= 1'b0;
            z_o       <= '0;
        end else begin
            z_valid_o <= valid_i;
            if (valid_i) begin
                z_o <= z_next;
            end
        end
    end

    // Signed saturation never flips the sign of the wide value
    a_sat_sign: assert property (
        @(posedge clock_i) disable iff (s_reset)
        (valid_i && op_i.out_sum && op_i.saturate_en && signed_mode)
        |=> (z_o[Z_W-1] == $past(shr_val[ACC_W-1]))
    );

endmodule

// File: design/dsp_slice_top.sv
// DSP slice top level
// Registered-in, registered-out 20x18 MAC with a two cycle result latency

`timescale 1ns/1ps

module dsp_slice_top (
    input  logic             clock_i,
    input  logic             s_reset,

    input  logic             op_valid_i,
    input  dsp_pkg::dsp_op_t op_i,

    output logic             z_valid_o,
    output dsp_pkg::result_t z_o
);

    import dsp_pkg::*;

    logic    reg_valid;
    dsp_op_t reg_op;
    acc_t    product;
    acc_t    sum;

    // Stage 1, input register
    dsp_input_stage u_input_stage (
        .clock_i     (clock_i),
        .s_reset     (s_reset),
        .op_valid_i  (op_valid_i),
        .op_i        (op_i),
        .reg_valid_o (reg_valid),
        .reg_op_o    (reg_op)
    );

    dsp_multiplier u_multiplier (
        .op_i      (reg_op),
        .product_o (product)
    );

    dsp_accumulator u_accumulator (
        .clock_i   (clock_i),
        .s_reset   (s_reset),
        .valid_i   (reg_valid),
        .op_i      (reg_op),
        .product_i (product),
        .sum_o     (sum)
    );

    // Stage 2, post-processing and output register
    dsp_output_stage u_output_stage (
        .clock_i   (clock_i),
        .s_reset   (s_reset),
        .valid_i   (reg_valid),
        .op_i      (reg_op),
        .product_i (product),
        .sum_i     (sum),
        .z_valid_o (z_valid_o),
        .z_o       (z_o)
    );

endmodule

// File: bench/dsp_ref_model.svh
// DSP slice reference model
// Expected results from the slice arithmetic rules, plus typed compare tasks

`ifndef DSP_REF_MODEL_SVH
`define DSP_REF_MODEL_SVH

// 38-bit limits held at accumulator width
localparam logic signed [ACC_W-1:0] S_MAX = 64'sh0000_001F_FFFF_FFFF;
localparam logic signed [ACC_W-1:0] S_MIN = -64'sh0000_0020_0000_0000;
localparam acc_t                    U_MAX = 64'h0000_003F_FFFF_FFFF;

acc_t model_acc;

// Full-width signed multiply of the extended operands
function automatic acc_t ref_product(dsp_op_t op);
    logic signed [ACC_W-1:0] ext_a;
    logic signed [ACC_W-1:0] ext_b;
    ext_a = {{(ACC_W-A_W){op.a[A_W-1] & !op.unsigned_a}}, op.a};
    ext_b = {{(ACC_W-B_W){op.b[B_W-1] & !op.unsigned_b}}, op.b};
    return ext_a * ext_b;
endfunction

function automatic result_t post_process(acc_t sum, dsp_op_t op);
    logic                    signed_mode;
    acc_t                    v;
    logic signed [ACC_W-1:0] sv;
    signed_mode = !(op.unsigned_a && op.unsigned_b);
    v = sum;
    if (op.round_en && (op.shift != 0)) begin
        v = v + (acc_t'(1) << (op.shift - 1));
    end
    if (signed_mode) begin
        sv = $signed(v) >>> op.shift;
        v  = sv;
    end else begin
        v = v >> op.shift;
    end
    if (op.saturate_en && signed_mode) begin
        sv = v;
        if (sv > S_MAX) begin
            return S_MAX[Z_W-1:0];
        end
        if (sv < S_MIN) begin
            return S_MIN[Z_W-1:0];
        end
    end
    if (op.saturate_en && !signed_mode && (v > U_MAX)) begin
        return '1;
    end
    return v[Z_W-1:0];
endfunction

// Expected z_o for one valid operation, advancing the model accumulator
function automatic result_t predict_result(dsp_op_t op);
    acc_t prod;
    acc_t base;
    acc_t sum;
    prod = ref_product(op);
    base = op.acc_zero ? '0 : model_acc;
    sum  = op.subtract ? (base - prod) : (base + prod);
    if (op.load_acc) begin
        model_acc = sum;
    end
    return op.out_sum ? post_process(sum, op) : prod[Z_W-1:0];
endfunction

task automatic check_result(result_t got, result_t exp, string what);
    if (got !== exp) begin
        stop_on_error($sformatf("Fail at %0d ns: %s, z_o %h, expected %h",
                                $time, what, got, exp));
    end
endtask

task automatic check_valid(logic got, logic exp, string what);
    if (got !== exp) begin
        stop_on_error($sformatf("Fail at %0d ns: %s, z_valid_o %b, expected %b",
                                $time, what, got, exp));
    end
endtask

`endif

// File: bench/dsp_slice_tb.sv
// DSP slice testbench
// Random and directed MAC operations checked against a reference model

`timescale 1ns/1ps

module dsp_slice_tb;

    import dsp_pkg::*;

    localparam int TIMEOUT_CYCLES = 1200;

    logic    clock_i;
    logic    s_reset;
    logic    op_valid_i;
    dsp_op_t op_i;
    logic    z_valid_o;
    result_t z_o;

    integer  seed;
    int      cycle_count;
    logic    seen_result;
    result_t exp_q[$];
    int      due_q[$];

    dsp_slice_top uut (
        .clock_i    (clock_i),
        .s_reset    (s_reset),
        .op_valid_i (op_valid_i),
        .op_i       (op_i),
        .z_valid_o  (z_valid_o),
        .z_o        (z_o)
    );

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    `include "dsp_ref_model.svh"

    initial begin
        clock_i = 1'b0;
        forever #50 clock_i = ~clock_i;
    end

    // Edge counter, also bounds the run
    always @(posedge clock_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("Timeout after %0d clock cycles", cycle_count));
        end
    end

    // Compare at the falling edge, where outputs are settled
    always @(negedge clock_i) begin
        if (!s_reset) begin
            if ((exp_q.size() != 0) && (due_q[0] == cycle_count)) begin
                check_valid(z_valid_o, 1'b1, "result due");
                check_result(z_o, exp_q[0], "result value");
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
                seen_result = 1'b1;
            end else begin
                check_valid(z_valid_o, 1'b0, "no result due");
                if (!seen_result) begin
                    check_result(z_o, '0, "idle output after reset");
                end
            end
        end
    end

    function automatic dsp_op_t random_op();
        dsp_op_t     op;
        logic [31:0] r;
        r  = $random(seed);
        op.a = r[A_W-1:0];
        r  = $random(seed);
        op.b = r[B_W-1:0];
        r  = $random(seed);
        op.unsigned_a  = r[0];
        op.unsigned_b  = r[1];
        op.subtract    = r[2];
        op.load_acc    = r[3];
        op.acc_zero    = r[4];
        op.out_sum     = r[5];
        op.round_en    = r[6];
        op.saturate_en = r[7];
        op.shift       = r[13:8];
        return op;
    endfunction

    task automatic send_op(dsp_op_t op);
        @(posedge clock_i);
        op_valid_i <= 1'b1;
        op_i       <= op;
        exp_q.push_back(predict_result(op));
        // Count still shows the previous edge, result is seen after the second register
        due_q.push_back(cycle_count + 3);
    endtask

    task automatic idle_cycle();
        @(posedge clock_i);
        op_valid_i <= 1'b0;
        op_i       <= '0;
    endtask

    // Roughly one idle cycle in eight
    task automatic insert_gap();
        logic [31:0] r;
        r = $random(seed);
        if (r[2:0] == 3'd0) begin
            idle_cycle();
        end
    endtask

    // Repeated large products accumulated until the result clamps
    task automatic saturate_run(operand_a_t a, operand_b_t b, logic uns, shift_t sh, logic rnd);
        dsp_op_t op;
        op = '0;
        op.a = a;
        op.b = b;
        op.unsigned_a  = uns;
        op.unsigned_b  = uns;
        op.load_acc    = 1'b1;
        op.out_sum     = 1'b1;
        op.saturate_en = 1'b1;
        op.round_en    = rnd;
        op.shift       = sh;
        for (int k = 0; k < 6; k++) begin
            op.acc_zero = (k == 0);
            send_op(op);
        end
    endtask

    initial begin
        dsp_op_t op;
        seed        = 79;
        cycle_count = 0;
        seen_result = 1'b0;
        model_acc   = '0;
        s_reset     = 1'b1;
        op_valid_i  = 1'b0;
        op_i        = '0;
        repeat (16) @(posedge clock_i);
        s_reset <= 1'b0;
        repeat (6) idle_cycle();

        // Raw product, random signedness
        for (int i = 0; i < 200; i++) begin
            op = random_op();
            op.out_sum = 1'b0;
            send_op(op);
            insert_gap();
        end

        // Running sum from a restart, some cycles without load
        for (int i = 0; i < 31; i++) begin
            op = random_op();
            op.unsigned_a  = 1'b0;
            op.unsigned_b  = 1'b0;
            op.subtract    = 1'b0;
            op.acc_zero    = (i == 0);
            op.load_acc    = (i % 4 != 3);
            op.out_sum     = 1'b1;
            op.round_en    = 1'b0;
            op.saturate_en = 1'b0;
            op.shift       = '0;
            send_op(op);
            if ((i == 10) || (i == 20)) begin
                idle_cycle();
            end
        end

        // Subtract with feedback or zero addend
        for (int i = 0; i < 100; i++) begin
            op = random_op();
            op.subtract = 1'b1;
            op.load_acc = 1'b1;
            op.out_sum  = 1'b1;
            op.shift    = '0;
            send_op(op);
            insert_gap();
        end

        // Post-processing, each case in signed then unsigned mode
        for (int i = 0; i < 100; i++) begin
            op = random_op();
            op.out_sum    = 1'b1;
            op.unsigned_a = 1'b0;
            op.unsigned_b = 1'b0;
            send_op(op);
            op.unsigned_a = 1'b1;
            op.unsigned_b = 1'b1;
            send_op(op);
            insert_gap();
        end

        saturate_run(20'h7FFFF, 18'h1FFFF, 1'b0, 6'd0, 1'b0);
        saturate_run(20'h80000, 18'h1FFFF, 1'b0, 6'd0, 1'b0);
        saturate_run(20'hFFFFF, 18'h3FFFF, 1'b1, 6'd0, 1'b0);
        saturate_run(20'h80000, 18'h3FFFF, 1'b1, 6'd0, 1'b0);
        saturate_run(20'h7FFFF, 18'h1FFFF, 1'b0, 6'd1, 1'b1);
        saturate_run(20'hFFFFF, 18'h3FFFF, 1'b1, 6'd1, 1'b1);

        // Two register stages, so four idle cycles drain the pipeline
        repeat (4) idle_cycle();
        if (exp_q.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d expected results never appeared on z_o", exp_q.size()));
        end
    end

endmodule

// File: sim.f
+incdir+bench
design/dsp_pkg.sv
design/dsp_input_stage.sv
design/dsp_multiplier.sv
design/dsp_accumulator.sv
design/dsp_output_stage.sv
design/dsp_slice_top.sv
bench/dsp_slice_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DSP slice testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module dsp_slice_tb -f sim.f -o dsp_sim &&
./obj_dir/dsp_sim | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
